// ==== hw/alu_consts.svh ====
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

////////////////////////////////////////
// Execute slice sizing
////////////////////////////////////////

// Micro-op queue entries between issue and execute
`define ALU_FIFO_DEPTH 4

// Destination register tag carried with each op
`define ALU_DEST_W 5

// Scalar adder width, result is sign-extended above it
`define ALU_ADD_W 32

`endif

// ==== hw/alu_pkg.sv ====
`include "alu_consts.svh"

package alu_pkg;

    ////////////////////////////////////////
    // Operation and operand select codes
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_AND       = 4'h0,
        OP_ADD       = 4'h1,
        OP_PASSA     = 4'h2,
        OP_PASSB     = 4'h3,
        OP_PASS0     = 4'h4,
        OP_PASS1     = 4'h5,
        OP_NOTA      = 4'h6,
        OP_SAL       = 4'h7,
        OP_SAR       = 4'h8,
        OP_PADDW     = 4'h9,
        OP_PADDD     = 4'ha,
        OP_PACKSSWB  = 4'hb,
        OP_PACKSSDW  = 4'hc,
        OP_PUNPCKHBW = 4'hd,
        OP_PUNPCKHWD = 4'he
    } alu_op_e;

    // Adder B-side select, codes 3 and 7 give zero
    typedef enum logic [2:0] {
        IMM_B  = 3'd0,
        IMM_P2 = 3'd1,
        IMM_P4 = 3'd2,
        IMM_P6 = 3'd4,
        IMM_M2 = 3'd5,
        IMM_M4 = 3'd6
    } imm_sel_e;

    ////////////////////////////////////////
    // Data words and transfer records
    ////////////////////////////////////////

    // One MMX register, seen whole or as lanes
    typedef union packed {
        logic [63:0]      q;
        logic [7:0][7:0]  b;
        logic [3:0][15:0] w;
        logic [1:0][31:0] d;
    } mmx_word_u;

    typedef struct packed {
        alu_op_e                op;
        mmx_word_u              a;
        mmx_word_u              b;
        imm_sel_e               imm_sel;
        logic                   and_int;
        logic [`ALU_DEST_W-1:0] dest;
    } alu_req_t;

    typedef struct packed {
        alu_op_e                op;
        mmx_word_u              a;
        mmx_word_u              b;
        logic [`ALU_DEST_W-1:0] dest;
    } alu_uop_t;

    typedef struct packed {
        logic [63:0]            value;
        logic                   carry;
        logic [`ALU_DEST_W-1:0] dest;
    } alu_result_t;

endpackage

// ==== hw/alu_issue.sv ====
`include "alu_consts.svh"

module alu_issue
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  alu_req_t req,
    output logic     push,
    output alu_uop_t uop
);

    logic [`ALU_ADD_W-1:0] imm;
    mmx_word_u             b_res;

    // Adder second operand, same choices as the old 8-way mux
    always_comb begin
        case (req.imm_sel)
            IMM_B:   imm = req.b.q[`ALU_ADD_W-1:0];
            IMM_P2:  imm = `ALU_ADD_W'd2;
            IMM_P4:  imm = `ALU_ADD_W'd4;
            IMM_P6:  imm = `ALU_ADD_W'd6;
            IMM_M2:  imm = -`ALU_ADD_W'd2;
            IMM_M4:  imm = -`ALU_ADD_W'd4;
            default: imm = '0;
        endcase
    end

    always_comb begin
        if (req.op == OP_ADD) begin
            b_res.q = {{(64 - `ALU_ADD_W){1'b0}}, imm};
        end else if (req.op == OP_AND && req.and_int) begin
            // Keep only the low halfword of A
            b_res.q = 64'h0000_0000_0000_ffff;
        end else begin
            b_res.q = req.b.q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            uop.op   <= req.op;
            uop.a    <= req.a;
            uop.b    <= b_res;
            uop.dest <= req.dest;
        end
    end

endmodule

// ==== hw/alu_uop_fifo.sv ====
`include "alu_consts.svh"

module alu_uop_fifo
    import alu_pkg::*;
#(
    parameter int DEPTH = `ALU_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  alu_uop_t uop,
    input  logic     pop,
    output alu_uop_t head_uop,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    alu_uop_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // A push into a full queue is dropped unless a pop frees a slot
    assign wr_en = push && (!full || pop);
    assign rd_en = pop && !empty;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign head_uop = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= uop;
        end
    end

endmodule

// ==== hw/alu_simd_unit.sv ====
module alu_simd_unit
    import alu_pkg::*;
(
    input  alu_op_e   op,
    input  mmx_word_u a,
    input  mmx_word_u b,
    output mmx_word_u y
);

    ////////////////////////////////////////
    // Signed saturation helpers
    ////////////////////////////////////////

    function automatic logic [7:0] sat_w2b(input logic [15:0] v);
        logic signed [15:0] s;
        s = $signed(v);
        if (s > 16'sd127) begin
            return 8'h7f;
        end else if (s < -16'sd128) begin
            return 8'h80;
        end
        return v[7:0];
    endfunction

    function automatic logic [15:0] sat_d2w(input logic [31:0] v);
        logic signed [31:0] s;
        s = $signed(v);
        if (s > 32'sd32767) begin
            return 16'h7fff;
        end else if (s < -32'sd32768) begin
            return 16'h8000;
        end
        return v[15:0];
    endfunction

    ////////////////////////////////////////
    // Lane logic
    ////////////////////////////////////////

    always_comb begin
        y.q = '0;
        case (op)
            OP_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    y.w[i] = a.w[i] + b.w[i];
                end
            end
            OP_PADDD: begin
                for (int i = 0; i < 2; i++) begin
                    y.d[i] = a.d[i] + b.d[i];
                end
            end
            // A words fill the low bytes, B words the high bytes
            OP_PACKSSWB: begin
                for (int i = 0; i < 4; i++) begin
                    y.b[i]     = sat_w2b(a.w[i]);
                    y.b[i + 4] = sat_w2b(b.w[i]);
                end
            end
            OP_PACKSSDW: begin
                for (int i = 0; i < 2; i++) begin
                    y.w[i]     = sat_d2w(a.d[i]);
                    y.w[i + 2] = sat_d2w(b.d[i]);
                end
            end
            // High halves interleaved, A element lower in each pair
            OP_PUNPCKHBW: begin
                for (int i = 0; i < 4; i++) begin
                    y.b[2 * i]     = a.b[4 + i];
                    y.b[2 * i + 1] = b.b[4 + i];
                end
            end
            OP_PUNPCKHWD: begin
                for (int i = 0; i < 2; i++) begin
                    y.w[2 * i]     = a.w[2 + i];
                    y.w[2 * i + 1] = b.w[2 + i];
                end
            end
            default: y.q = '0;
        endcase
    end

endmodule

// ==== hw/alu_exec.sv ====
`include "alu_consts.svh"

module alu_exec
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  alu_uop_t    head_uop,
    input  logic        empty,
    input  logic        hold,
    output logic        pop,
    output logic        result_valid,
    output alu_result_t result
);

    logic [`ALU_ADD_W:0] sum;
    mmx_word_u           simd_y;
    logic [63:0]         value_d;
    logic                carry_d;
    logic [5:0]          shamt;

    // Take the head whenever writeback is not stalling us
    assign pop = !empty && !hold;

    assign shamt = head_uop.b.q[5:0];

    // Adder with carry out in the top bit
    assign sum = {1'b0, head_uop.a.q[`ALU_ADD_W-1:0]}
               + {1'b0, head_uop.b.q[`ALU_ADD_W-1:0]};

    alu_simd_unit i_simd (
        .op (head_uop.op),
        .a  (head_uop.a),
        .b  (head_uop.b),
        .y  (simd_y)
    );

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    always_comb begin
        carry_d = 1'b0;
        case (head_uop.op)
            OP_AND:   value_d = head_uop.a.q & head_uop.b.q;
            OP_ADD: begin
                value_d = {{(64 - `ALU_ADD_W){sum[`ALU_ADD_W-1]}}, sum[`ALU_ADD_W-1:0]};
                carry_d = sum[`ALU_ADD_W];
            end
            OP_PASSA: value_d = head_uop.a.q;
            OP_PASSB: value_d = head_uop.b.q;
            OP_PASS0: value_d = '0;
            OP_PASS1: value_d = '1;
            OP_NOTA:  value_d = ~head_uop.a.q;
            OP_SAL:   value_d = head_uop.a.q << shamt;
            OP_SAR:   value_d = $signed(head_uop.a.q) >>> shamt;
            OP_PADDW,
            OP_PADDD,
            OP_PACKSSWB,
            OP_PACKSSDW,
            OP_PUNPCKHBW,
            OP_PUNPCKHWD: begin
                value_d = simd_y.q;
            end
            default:  value_d = '0;
        endcase
    end

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= pop;
        end
    end

    // Payload only moves on a pop, tag rides along
    always_ff @(posedge clk) begin
        if (pop) begin
            result.value <= value_d;
            result.carry <= carry_d;
            result.dest  <= head_uop.dest;
        end
    end

endmodule

// ==== hw/alu_top.sv ====
module alu_top
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        issue,
    input  alu_req_t    req,
    input  logic        hold,
    output logic        full,
    output logic        result_valid,
    output alu_result_t result
);

    logic     push;
    logic     pop;
    logic     empty;
    alu_uop_t uop;
    alu_uop_t head_uop;

    alu_issue i_issue (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .req   (req),
        .push  (push),
        .uop   (uop)
    );

    alu_uop_fifo i_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .uop      (uop),
        .pop      (pop),
        .head_uop (head_uop),
        .empty    (empty),
        .full     (full)
    );

    alu_exec i_exec (
        .clk          (clk),
        .rst          (rst),
        .head_uop     (head_uop),
        .empty        (empty),
        .hold         (hold),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== dv/alu_asserts.sv ====
module alu_asserts (
    input logic clk,
    input logic rst,
    input logic hold,
    input logic full,
    input logic push,
    input logic pop,
    input logic result_valid
);

    // Read by the testbench for its closing line
    int fail_count = 0;

    // Register is cleared after the first reset edge
    a_quiet_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !result_valid)
        else begin
            $error("result_valid high while rst is asserted");
            fail_count++;
        end

    a_no_pop_on_hold: assert property (@(posedge clk) disable iff (rst) hold |-> !pop)
        else begin
            $error("pop raised while hold is high");
            fail_count++;
        end

    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst) (push && full) |-> pop)
        else begin
            $error("push into a full queue with no pop");
            fail_count++;
        end

endmodule

// ==== dv/alu_checker.sv ====
`include "alu_consts.svh"

module alu_checker
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        issue,
    input  alu_req_t    req,
    input  logic        hold,
    input  logic        full,
    input  logic        result_valid,
    input  alu_result_t result,
    input  logic        end_of_test,
    output int          mismatch_errs,
    output int          protocol_errs,
    output int          pending
);

    alu_result_t expected_q [$];
    alu_result_t exp_r;
    logic        exp_push;
    logic        exp_pop;
    logic        exp_valid;
    int          occupancy;
    logic        full_seen = 1'b0;
    logic        final_done = 1'b0;
    int          n_mismatch = 0;
    int          n_protocol = 0;
    int          n_pending = 0;

    assign mismatch_errs = n_mismatch;
    assign protocol_errs = n_protocol;
    assign pending       = n_pending;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Clamp to the signed range of a lane, low bits hold the lane value
    function automatic logic [31:0] saturate(input longint v, input int bits);
        longint hi;
        longint lo;
        hi = (longint'(1) << (bits - 1)) - 1;
        lo = -hi - 1;
        if (v > hi) begin
            return 32'(hi);
        end
        if (v < lo) begin
            return 32'(lo);
        end
        return 32'(v);
    endfunction

    function automatic alu_result_t alu_model(input alu_req_t r);
        alu_result_t res;
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] addend;
        logic [32:0] sum;
        logic [31:0] s;
        a = r.a.q;
        b = r.b.q;
        res.value = '0;
        res.carry = 1'b0;
        res.dest  = r.dest;
        case (r.op)
            OP_AND:   res.value = r.and_int ? (a & 64'hffff) : (a & b);
            OP_ADD: begin
                case (r.imm_sel)
                    IMM_B:   addend = b[31:0];
                    IMM_P2:  addend = 32'd2;
                    IMM_P4:  addend = 32'd4;
                    IMM_P6:  addend = 32'd6;
                    IMM_M2:  addend = 32'hffff_fffe;
                    IMM_M4:  addend = 32'hffff_fffc;
                    default: addend = 32'd0;
                endcase
                sum = {1'b0, a[31:0]} + {1'b0, addend};
                res.carry = sum[32];
                res.value = {{32{sum[31]}}, sum[31:0]};
            end
            OP_PASSA: res.value = a;
            OP_PASSB: res.value = b;
            OP_PASS0: res.value = 64'h0;
            OP_PASS1: res.value = {64{1'b1}};
            OP_NOTA:  res.value = ~a;
            OP_SAL:   res.value = a << b[5:0];
            OP_SAR:   res.value = $signed(a) >>> b[5:0];
            OP_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    res.value[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
                end
            end
            OP_PADDD: begin
                for (int i = 0; i < 2; i++) begin
                    res.value[32*i +: 32] = a[32*i +: 32] + b[32*i +: 32];
                end
            end
            OP_PACKSSWB: begin
                for (int i = 0; i < 4; i++) begin
                    s = saturate(longint'($signed(a[16*i +: 16])), 8);
                    res.value[8*i +: 8] = s[7:0];
                    s = saturate(longint'($signed(b[16*i +: 16])), 8);
                    res.value[32 + 8*i +: 8] = s[7:0];
                end
            end
            OP_PACKSSDW: begin
                for (int i = 0; i < 2; i++) begin
                    s = saturate(longint'($signed(a[32*i +: 32])), 16);
                    res.value[16*i +: 16] = s[15:0];
                    s = saturate(longint'($signed(b[32*i +: 32])), 16);
                    res.value[32 + 16*i +: 16] = s[15:0];
                end
            end
            // High halves, A in the lower slot of each pair
            OP_PUNPCKHBW: begin
                for (int i = 0; i < 4; i++) begin
                    res.value[16*i +: 8]     = a[32 + 8*i +: 8];
                    res.value[16*i + 8 +: 8] = b[32 + 8*i +: 8];
                end
            end
            OP_PUNPCKHWD: begin
                for (int i = 0; i < 2; i++) begin
                    res.value[32*i +: 16]      = a[32 + 16*i +: 16];
                    res.value[32*i + 16 +: 16] = b[32 + 16*i +: 16];
                end
            end
            default: res.value = 64'h0;
        endcase
        return res;
    endfunction

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            n_mismatch++;
        end
    endtask

    ////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            exp_push  <= 1'b0;
            exp_valid <= 1'b0;
            occupancy <= 0;
        end else begin
            // Queue is popped whenever it holds an entry and writeback is free
            exp_pop = (occupancy != 0) && !hold;
            compare_field("full", 64'(full), 64'(occupancy == `ALU_FIFO_DEPTH));
            compare_field("result_valid", 64'(result_valid), 64'(exp_valid));
            if (issue) begin
                expected_q.push_back(alu_model(req));
                n_pending++;
            end
            if (full) begin
                full_seen = 1'b1;
            end
            if (result_valid) begin
                if (expected_q.size() == 0) begin
                    $display("ERROR: result_valid with no request outstanding");
                    n_protocol++;
                end else begin
                    exp_r = expected_q.pop_front();
                    n_pending--;
                    compare_field("result.value", result.value, exp_r.value);
                    compare_field("result.carry", 64'(result.carry), 64'(exp_r.carry));
                    compare_field("result.dest", 64'(result.dest), 64'(exp_r.dest));
                end
            end
            if (end_of_test && !final_done) begin
                final_done = 1'b1;
                if (n_pending != 0) begin
                    $display("ERROR: %0d expected results never came out", n_pending);
                    n_protocol++;
                end
                if (!full_seen) begin
                    $display("ERROR: the queue never reported full during hold bursts");
                    n_protocol++;
                end
            end
            exp_push  <= issue;
            exp_valid <= exp_pop;
            occupancy <= occupancy + int'(exp_push) - int'(exp_pop);
        end
    end

endmodule

// ==== dv/alu_tb.sv ====
`include "alu_consts.svh"

module alu_tb
    import alu_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int N_LOGIC      = 40;
    localparam int N_ADD        = 40;
    localparam int N_SHIFT      = 32;
    localparam int N_SIMD       = 60;
    localparam int N_HOLD       = 30;
    localparam int N_DENSE      = 40;
    localparam int N_TOTAL      = N_LOGIC + N_ADD + N_SHIFT + N_SIMD + N_HOLD + N_DENSE;
    localparam int WATCHDOG_TIME = (N_TOTAL * 20 + RESET_CYCLES) * CLK_PERIOD;

    // Op groups for the stimulus phases
    localparam int K_LOGIC = 0;
    localparam int K_ADD   = 1;
    localparam int K_SHIFT = 2;
    localparam int K_SIMD  = 3;
    localparam int K_ANY   = 4;

    logic        clk;
    logic        rst;
    logic        issue;
    logic        hold;
    logic        full;
    logic        result_valid;
    logic        end_of_test;
    alu_req_t    req;
    alu_result_t result;
    int          mismatch_errs;
    int          protocol_errs;
    int          pending;
    int          assert_errs;
    logic [31:0] lfsr_state = 32'h704b_223f;
    int          add_sel = 0;

    alu_op_e logic_ops [6] = '{OP_AND, OP_PASS0, OP_PASSA, OP_PASSB, OP_NOTA, OP_PASS1};
    alu_op_e simd_ops [6]  = '{OP_PADDW, OP_PADDD, OP_PACKSSWB, OP_PACKSSDW,
                               OP_PUNPCKHBW, OP_PUNPCKHWD};

    alu_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .req          (req),
        .hold         (hold),
        .full         (full),
        .result_valid (result_valid),
        .result       (result)
    );

    alu_checker i_chk (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .req           (req),
        .hold          (hold),
        .full          (full),
        .result_valid  (result_valid),
        .result        (result),
        .end_of_test   (end_of_test),
        .mismatch_errs (mismatch_errs),
        .protocol_errs (protocol_errs),
        .pending       (pending)
    );

    bind alu_top alu_asserts i_asserts (
        .clk          (clk),
        .rst          (rst),
        .hold         (hold),
        .full         (full),
        .push         (push),
        .pop          (pop),
        .result_valid (result_valid)
    );

    assign assert_errs = i_dut.i_asserts.fail_count;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic take_bit();
        logic bit_out;
        bit_out = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (bit_out ? 32'h8020_0003 : 32'h0);
        return bit_out;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(take_bit());
        end
        return v;
    endfunction

    function automatic logic [63:0] take_word();
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 64; i++) begin
            w = {w[62:0], take_bit()};
        end
        return w;
    endfunction

    // Some lanes shrunk to fit the narrow range, so packs also pass values through
    function automatic logic [63:0] shrink_lanes(input logic [63:0] v, input int w);
        logic [63:0] r;
        r = v;
        for (int i = 0; i < 64 / w; i++) begin
            if (take_bit()) begin
                for (int k = w / 2; k < w; k++) begin
                    r[i * w + k] = v[i * w + w / 2 - 1];
                end
            end
        end
        return r;
    endfunction

    function automatic alu_req_t make_req(input int kind);
        alu_req_t r;
        r.a.q     = take_word();
        r.b.q     = take_word();
        r.imm_sel = imm_sel_e'(3'(take_bits(3)));
        r.and_int = take_bit();
        r.dest    = `ALU_DEST_W'(take_bits(`ALU_DEST_W));
        case (kind)
            K_LOGIC: r.op = logic_ops[take_bits(3) % 6];
            K_ADD: begin
                // Walk all eight select codes in turn
                r.op = OP_ADD;
                r.imm_sel = imm_sel_e'(3'(add_sel));
                add_sel++;
            end
            K_SHIFT: r.op = take_bit() ? OP_SAR : OP_SAL;
            K_SIMD:  r.op = simd_ops[take_bits(3) % 6];
            default: r.op = alu_op_e'(4'(take_bits(4) % 15));
        endcase
        if (r.op == OP_PACKSSWB) begin
            r.a.q = shrink_lanes(r.a.q, 16);
            r.b.q = shrink_lanes(r.b.q, 16);
        end else if (r.op == OP_PACKSSDW) begin
            r.a.q = shrink_lanes(r.a.q, 32);
            r.b.q = shrink_lanes(r.b.q, 32);
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic run_phase(input int kind, input int count, input bit bursts,
                             input bit dense);
        int   issued;
        int   burst_left;
        logic issued_last;
        issued = 0;
        burst_left = 0;
        issued_last = 1'b0;
        while (issued < count) begin
            @(posedge clk);
            #1;
            if (bursts && burst_left == 0 && take_bits(3) == 0) begin
                burst_left = 8 + take_bits(3);
            end
            hold = (burst_left > 0);
            if (burst_left > 0) begin
                burst_left--;
            end
            // One push may still be in flight, it must not land on a full queue
            if (!full && !(issued_last && hold) && (dense || take_bit())) begin
                issue = 1'b1;
                req = make_req(kind);
                issued++;
                issued_last = 1'b1;
            end else begin
                issue = 1'b0;
                issued_last = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        issue = 1'b0;
        hold = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        issue = 1'b0;
        hold = 1'b0;
        req = '0;
        end_of_test = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        run_phase(K_LOGIC, N_LOGIC, 1'b0, 1'b0);
        run_phase(K_ADD, N_ADD, 1'b0, 1'b0);
        run_phase(K_SHIFT, N_SHIFT, 1'b0, 1'b0);
        run_phase(K_SIMD, N_SIMD, 1'b1, 1'b0);
        run_phase(K_ANY, N_HOLD, 1'b1, 1'b1);
        run_phase(K_ANY, N_DENSE, 1'b0, 1'b1);

        // Drain, then a few idle cycles to catch stray results
        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        #1;
        end_of_test = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        $display("Closing report: %0d mismatches, %0d protocol errors, %0d assertion failures",
                 mismatch_errs, protocol_errs, assert_errs);
        if (mismatch_errs + protocol_errs + assert_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: run still going after %0d time units, %0d results pending",
                 WATCHDOG_TIME, pending);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/alu_pkg.sv
hw/alu_issue.sv
hw/alu_uop_fifo.sv
hw/alu_simd_unit.sv
hw/alu_exec.sv
hw/alu_top.sv
dv/alu_asserts.sv
dv/alu_checker.sv
dv/alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module alu_tb -o alu_sim \
    && ./obj_dir/alu_sim +verilator+error+limit+100 > sim.log 2>&1 \
    && ! grep -q "Test failures found" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
